// File: src/thumb_decode_macros.svh
////////////////////////////////////////
// Sizing and fixed encodings for the
// compressed instruction expander.
// THUMB_LANES is 2 here, 4 also works.
////////////////////////////////////////

`ifndef THUMB_DECODE_MACROS_SVH
`define THUMB_DECODE_MACROS_SVH

////////////////////////////////////////
// Lane count and widths
////////////////////////////////////////

// Halfwords per fetch word, one lane each
`define THUMB_LANES 2

// Compressed instruction width
`define HALF_W 16

// Expanded ARM instruction width
`define ARM_W 32

////////////////////////////////////////
// Fixed ARM encodings
////////////////////////////////////////

// Always condition, top nibble of most words
`define COND_AL 4'b1110

// Architectural register numbers
`define REG_SP 4'd13     // Stack pointer
`define REG_PC 4'd15     // Program counter

`endif

// File: src/thumb_decode_pkg.sv
////////////////////////////////////////
// Types shared by fetch, lanes, issue.
// Lane 0 always takes the low halfword
// of the fetch word.
////////////////////////////////////////

`include "thumb_decode_macros.svh"

package thumb_decode_pkg;

////////////////////////////////////////
// ARM field encodings
////////////////////////////////////////

// Data-processing opcodes, bits 24:21
typedef enum logic [3:0] {
        ALU_AND = 4'd0,
        ALU_EOR = 4'd1,
        ALU_SUB = 4'd2,
        ALU_RSB = 4'd3,         // Used for NEG
        ALU_ADD = 4'd4,
        ALU_ADC = 4'd5,
        ALU_SBC = 4'd6,
        ALU_TST = 4'd8,         // Flags only
        ALU_CMP = 4'd10,        // Flags only
        ALU_CMN = 4'd11,        // Flags only
        ALU_ORR = 4'd12,
        ALU_MOV = 4'd13,
        ALU_BIC = 4'd14,
        ALU_MVN = 4'd15
} alu_op_t;

// Barrel shifter type, bits 6:5
typedef enum logic [1:0] {
        SH_LSL = 2'd0,
        SH_LSR = 2'd1,
        SH_ASR = 2'd2,
        SH_ROR = 2'd3
} shift_t;

////////////////////////////////////////
// Pipeline bundles
////////////////////////////////////////

// One fetch word plus per-slot enables
typedef struct packed {
        logic [`THUMB_LANES*`HALF_W-1:0] word;  // Lane k at bits k*16 +: 16
        logic [`THUMB_LANES-1:0]         mask;  // Slot k holds a real halfword
} fetch_bundle_t;

// What one lane sees
typedef struct packed {
        logic [`HALF_W-1:0] half;       // Compressed instruction
        logic               valid;      // Strobe and slot bit
} lane_in_t;

// What one lane produces
typedef struct packed {
        logic [`ARM_W-1:0] instr;       // Zero when undefined or idle
        logic              valid;
        logic              und;         // Not a kept format
} lane_out_t;

// Whole issue group, lane 0 lowest
typedef lane_out_t [`THUMB_LANES-1:0] issue_bundle_t;

endpackage

// File: src/thumb_fetch_split.sv
////////////////////////////////////////
// Fetch register and lane splitter.
// No back-pressure, every strobe taken.
// Masked slots see a zero halfword.
////////////////////////////////////////

`include "thumb_decode_macros.svh"

module thumb_fetch_split (
        input  logic                                          i_clk,
        input  logic                                          i_rst_n,
        input  logic                                          i_valid,   // One-cycle strobe
        input  thumb_decode_pkg::fetch_bundle_t               i_fetch,
        output thumb_decode_pkg::lane_in_t [`THUMB_LANES-1:0] o_lane     // One per lane
);

import thumb_decode_pkg::*;

fetch_bundle_t           fetch_q;       // Captured fetch word and mask
logic                    vld_q;         // Strobe, one cycle late
logic [`THUMB_LANES-1:0] lane_vld;      // Per-slot valid

////////////////////////////////////////
// Input register
////////////////////////////////////////

always_ff @(posedge i_clk or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                vld_q   <= 1'b0;
                fetch_q <= '0;
        end
        else
        begin
                vld_q <= i_valid;
                if (i_valid)
                        fetch_q <= i_fetch;     // Word only moves on a strobe
        end
end

////////////////////////////////////////
// Split into lanes
////////////////////////////////////////

assign lane_vld = {`THUMB_LANES{vld_q}} & fetch_q.mask;

always_comb
begin
        for (int k = 0; k < `THUMB_LANES; k++)
        begin
                o_lane[k].valid = lane_vld[k];
                // Dead slot gets zero, keeps lane inputs quiet
                o_lane[k].half  = fetch_q.word[k*`HALF_W +: `HALF_W] &
                                  {`HALF_W{lane_vld[k]}};
        end
end

endmodule

// File: src/thumb_lane_expand.sv
////////////////////////////////////////
// One pure-logic expansion lane.
// Loads, stores, BL pair and BLX are
// not handled and come out undefined.
////////////////////////////////////////

`include "thumb_decode_macros.svh"

module thumb_lane_expand (
        input  thumb_decode_pkg::lane_in_t  i_lane,     // Halfword and valid
        output thumb_decode_pkg::lane_out_t o_lane      // ARM word, valid, und
);

import thumb_decode_pkg::*;

////////////////////////////////////////
// Compressed format patterns
////////////////////////////////////////

localparam logic [`HALF_W-1:0] PAT_SWI     = 16'b1101_1111_????_????;
localparam logic [`HALF_W-1:0] PAT_ADD_SUB = 16'b0001_1???_????_????;
localparam logic [`HALF_W-1:0] PAT_BX      = 16'b0100_0111_0???_????;
localparam logic [`HALF_W-1:0] PAT_BCOND   = 16'b1101_????_????_????;
localparam logic [`HALF_W-1:0] PAT_B       = 16'b1110_0???_????_????;
localparam logic [`HALF_W-1:0] PAT_SHIFT   = 16'b000?_????_????_????;
localparam logic [`HALF_W-1:0] PAT_IMM8    = 16'b001?_????_????_????;
localparam logic [`HALF_W-1:0] PAT_ALU_LO  = 16'b0100_00??_????_????;
localparam logic [`HALF_W-1:0] PAT_ALU_HI  = 16'b0100_01??_????_????;

logic [`HALF_W-1:0] half;
logic [3:0]         lo_rd;      // Bits 2:0
logic [3:0]         lo_rs;      // Bits 5:3
logic [3:0]         lo_rn;      // Bits 8:6, also the 3-bit immediate
logic [3:0]         im_rd;      // Bits 10:8 of imm8 form
logic [3:0]         hi_rd;      // H1 and bits 2:0
logic [3:0]         hi_rs;      // H2 and bits 5:3
logic [`ARM_W-1:0]  instr;
logic               und;

// Always-condition data-processing word
function automatic logic [`ARM_W-1:0] dp_word(
        input logic       imm,
        input alu_op_t    op,
        input logic       s,
        input logic [3:0] rn,
        input logic [3:0] rd,
        input logic [11:0] op2
);
        dp_word = {`COND_AL, 2'b00, imm, op, s, rn, rd, op2};
endfunction

// Operand2 of Rm shifted by register Rs
function automatic logic [11:0] reg_shift(
        input logic [3:0] rs,
        input shift_t     sh,
        input logic [3:0] rm
);
        reg_shift = {rs, 1'b0, sh, 1'b1, rm};
endfunction

assign half  = i_lane.half;
assign lo_rd = {1'b0, half[2:0]};
assign lo_rs = {1'b0, half[5:3]};
assign lo_rn = {1'b0, half[8:6]};
assign im_rd = {1'b0, half[10:8]};
assign hi_rd = {half[7], half[2:0]};
assign hi_rs = {half[6], half[5:3]};

////////////////////////////////////////
// Format match and expansion
////////////////////////////////////////

always_comb
begin
        instr = '0;
        und   = 1'b0;

        if (i_lane.valid)
        begin
                if (half ==? PAT_SWI)                   // SWI imm8
                begin
                        instr = {`COND_AL, 4'b1111, 16'd0, half[7:0]};
                end
                else if (half ==? PAT_ADD_SUB)          // ADDS/SUBS low regs
                begin
                        case ({half[10], half[9]})
                        2'b00: instr = dp_word(1'b0, ALU_ADD, 1'b1, lo_rs, lo_rd,
                                               {8'd0, lo_rn});
                        2'b01: instr = dp_word(1'b0, ALU_SUB, 1'b1, lo_rs, lo_rd,
                                               {8'd0, lo_rn});
                        2'b10: instr = dp_word(1'b1, ALU_ADD, 1'b1, lo_rs, lo_rd,
                                               {8'd0, lo_rn});   // 3-bit imm
                        2'b11: instr = dp_word(1'b1, ALU_SUB, 1'b1, lo_rs, lo_rd,
                                               {8'd0, lo_rn});
                        endcase
                end
                else if (half ==? PAT_BX)               // BX Rm with any of 16
                begin
                        instr = {`COND_AL, 24'h12_fff1, half[6:3]};
                end
                else casez (half)
                PAT_BCOND:      // Cond from bits 11:8 and offset in halfwords
                        instr = {half[11:8], 3'b101, 1'b0, {16{half[7]}}, half[7:0]};
                PAT_B:
                        instr = {`COND_AL, 3'b101, 1'b0, {13{half[10]}}, half[10:0]};
                PAT_SHIFT:      // Op 11 already went to add/sub
                        instr = dp_word(1'b0, ALU_MOV, 1'b1, 4'd0, lo_rd,
                                        {half[10:6], shift_t'(half[12:11]), 1'b0, lo_rs});
                PAT_IMM8:
                begin
                        case (half[12:11])
                        2'd0: instr = dp_word(1'b1, ALU_MOV, 1'b1, im_rd, im_rd,
                                              {4'd0, half[7:0]});
                        2'd1: instr = dp_word(1'b1, ALU_CMP, 1'b1, im_rd, im_rd,
                                              {4'd0, half[7:0]});
                        2'd2: instr = dp_word(1'b1, ALU_ADD, 1'b1, im_rd, im_rd,
                                              {4'd0, half[7:0]});
                        2'd3: instr = dp_word(1'b1, ALU_SUB, 1'b1, im_rd, im_rd,
                                              {4'd0, half[7:0]});
                        endcase
                end
                PAT_ALU_LO:     // Rd = Rd op Rs with flags set
                begin
                        case (half[9:6])
                        4'd0:  instr = dp_word(1'b0, ALU_AND, 1'b1, lo_rd, lo_rd, {8'd0, lo_rs});
                        4'd1:  instr = dp_word(1'b0, ALU_EOR, 1'b1, lo_rd, lo_rd, {8'd0, lo_rs});
                        4'd2:  instr = dp_word(1'b0, ALU_MOV, 1'b1, lo_rd, lo_rd,
                                               reg_shift(lo_rs, SH_LSL, lo_rd));
                        4'd3:  instr = dp_word(1'b0, ALU_MOV, 1'b1, lo_rd, lo_rd,
                                               reg_shift(lo_rs, SH_LSR, lo_rd));
                        4'd4:  instr = dp_word(1'b0, ALU_MOV, 1'b1, lo_rd, lo_rd,
                                               reg_shift(lo_rs, SH_ASR, lo_rd));
                        4'd5:  instr = dp_word(1'b0, ALU_ADC, 1'b1, lo_rd, lo_rd, {8'd0, lo_rs});
                        4'd6:  instr = dp_word(1'b0, ALU_SBC, 1'b1, lo_rd, lo_rd, {8'd0, lo_rs});
                        4'd7:  instr = dp_word(1'b0, ALU_MOV, 1'b1, lo_rd, lo_rd,
                                               reg_shift(lo_rs, SH_ROR, lo_rd));
                        4'd8:  instr = dp_word(1'b0, ALU_TST, 1'b1, lo_rd, lo_rd, {8'd0, lo_rs});
                        4'd9:  instr = dp_word(1'b1, ALU_RSB, 1'b1, lo_rs, lo_rd, 12'd0); // NEG
                        4'd10: instr = dp_word(1'b0, ALU_CMP, 1'b1, lo_rd, lo_rd, {8'd0, lo_rs});
                        4'd11: instr = dp_word(1'b0, ALU_CMN, 1'b1, lo_rd, lo_rd, {8'd0, lo_rs});
                        4'd12: instr = dp_word(1'b0, ALU_ORR, 1'b1, lo_rd, lo_rd, {8'd0, lo_rs});
                        4'd13: instr = {`COND_AL, 7'b0000_000, 1'b1, lo_rd, 4'd0,
                                        lo_rd, 4'b1001, lo_rs};                 // MULS
                        4'd14: instr = dp_word(1'b0, ALU_BIC, 1'b1, lo_rd, lo_rd, {8'd0, lo_rs});
                        4'd15: instr = dp_word(1'b0, ALU_MVN, 1'b1, lo_rd, lo_rd, {8'd0, lo_rs});
                        endcase
                end
                PAT_ALU_HI:     // BX went first so op 3 left here is BLX
                begin
                        case (half[9:8])
                        2'd0: instr = dp_word(1'b0, ALU_ADD, 1'b0, hi_rd, hi_rd, {8'd0, hi_rs});
                        2'd1: instr = dp_word(1'b0, ALU_CMP, 1'b1, hi_rd, hi_rd, {8'd0, hi_rs});
                        2'd2: instr = dp_word(1'b0, ALU_MOV, 1'b0, hi_rd, hi_rd, {8'd0, hi_rs});
                        2'd3: und   = 1'b1;
                        endcase
                end
                default:
                        und = 1'b1;     // Loads, stores, push/pop, BL and the like
                endcase
        end
end

// Word stays zero on every undefined path
assign o_lane.instr = instr;
assign o_lane.valid = i_lane.valid;
assign o_lane.und   = und;

endmodule

// File: src/thumb_issue_collect.sv
////////////////////////////////////////
// Issue register for all lane results.
// Holds last group until next strobe.
////////////////////////////////////////

`include "thumb_decode_macros.svh"

module thumb_issue_collect (
        input  logic                                           i_clk,
        input  logic                                           i_rst_n,
        input  thumb_decode_pkg::lane_out_t [`THUMB_LANES-1:0] i_lane,   // From lanes
        output logic                                           o_valid,  // Any lane valid
        output thumb_decode_pkg::issue_bundle_t                o_issue
);

import thumb_decode_pkg::*;

issue_bundle_t issue_q;         // Registered lane results
logic          vld_q;           // Registered group strobe
logic          any_vld;

////////////////////////////////////////
// Group valid
////////////////////////////////////////

always_comb
begin
        any_vld = 1'b0;
        for (int k = 0; k < `THUMB_LANES; k++)
        begin
                any_vld = any_vld | i_lane[k].valid;    // OR over lanes
        end
end

////////////////////////////////////////
// Output register
////////////////////////////////////////

always_ff @(posedge i_clk or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                vld_q   <= 1'b0;
                issue_q <= '0;
        end
        else
        begin
                vld_q <= any_vld;               // Strobe, one cycle wide
                if (any_vld)
                        issue_q <= i_lane;      // Idle cycles keep old group
        end
end

assign o_valid = vld_q;
assign o_issue = issue_q;

endmodule

// File: src/thumb_decode_top.sv
////////////////////////////////////////
// Multi-lane compressed decoder top.
// Output comes 2 cycles after strobe,
// up to two groups in flight.
////////////////////////////////////////

`include "thumb_decode_macros.svh"

module thumb_decode_top (
        input  logic                            i_clk,
        input  logic                            i_rst_n,
        input  logic                            i_valid,        // Fetch strobe
        input  thumb_decode_pkg::fetch_bundle_t i_fetch,
        output logic                            o_valid,        // Issue strobe
        output thumb_decode_pkg::issue_bundle_t o_issue
);

import thumb_decode_pkg::*;

lane_in_t  [`THUMB_LANES-1:0] split_lane;       // Stage 1 to lanes
lane_out_t [`THUMB_LANES-1:0] exp_lane;         // Lanes to stage 2

////////////////////////////////////////
// Fetch stage
////////////////////////////////////////

thumb_fetch_split u_fetch_split (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .i_fetch (i_fetch),
        .o_lane  (split_lane)
);

// One expander per halfword
for (genvar k = 0; k < `THUMB_LANES; k++)
begin : g_lane
        thumb_lane_expand u_lane_expand (
                .i_lane (split_lane[k]),
                .o_lane (exp_lane[k])
        );
end

////////////////////////////////////////
// Issue stage
////////////////////////////////////////

thumb_issue_collect u_issue_collect (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_lane  (exp_lane),
        .o_valid (o_valid),
        .o_issue (o_issue)
);

endmodule

// File: verif/thumb_expand_model.svh
////////////////////////////////////////
// Expected expansion for the testbench.
// Include inside a module after the
// package import, lane_out_t is used.
////////////////////////////////////////

`ifndef THUMB_EXPAND_MODEL_SVH
`define THUMB_EXPAND_MODEL_SVH

// AL data-processing word from fields
function automatic logic [31:0] arm_dp(input logic i, input logic [3:0] op, input logic s,
                                       input logic [3:0] rn, input logic [3:0] rd,
                                       input logic [11:0] op2);
        return {4'b1110, 2'b00, i, op, s, rn, rd, op2};
endfunction

// Low-register ALU group, plain ops keep their number as ARM opcode
function automatic logic [31:0] alu_low(input logic [3:0] op, input logic [3:0] rd,
                                        input logic [3:0] rs);
        case (op)
        4'd2:    return arm_dp(1'b0, 4'd13, 1'b1, rd, rd, {rs, 4'b0001, rd});  // LSL by reg
        4'd3:    return arm_dp(1'b0, 4'd13, 1'b1, rd, rd, {rs, 4'b0011, rd});  // LSR by reg
        4'd4:    return arm_dp(1'b0, 4'd13, 1'b1, rd, rd, {rs, 4'b0101, rd});  // ASR by reg
        4'd7:    return arm_dp(1'b0, 4'd13, 1'b1, rd, rd, {rs, 4'b0111, rd});  // ROR by reg
        4'd9:    return arm_dp(1'b1, 4'd3, 1'b1, rs, rd, 12'd0);               // NEG
        4'd13:   return {4'b1110, 8'b0000_0001, rd, 4'd0, rd, 4'b1001, rs};   // MULS
        default: return arm_dp(1'b0, op, 1'b1, rd, rd, {8'd0, rs});
        endcase
endfunction

// One halfword in, one lane result out
function automatic lane_out_t expand_half(input logic [15:0] h, input logic v);
        lane_out_t  r;
        logic [3:0] rd, rs, r8, imm_op, hi_op;
        r       = '0;
        r.valid = v;
        rd      = {1'b0, h[2:0]};
        rs      = {1'b0, h[5:3]};
        r8      = {1'b0, h[10:8]};
        imm_op  = h[12] ? (h[11] ? 4'd2 : 4'd4) : (h[11] ? 4'd10 : 4'd13);  // MOV CMP ADD SUB
        hi_op   = h[8] ? 4'd10 : (h[9] ? 4'd13 : 4'd4);                    // ADD CMP MOV
        if (!v)
                return r;
        if (h[15:8] == 8'hdf)
                r.instr = {4'b1110, 4'hf, 16'd0, h[7:0]};                 // SWI
        else if (h[15:11] == 5'b00011)
                r.instr = arm_dp(h[10], h[9] ? 4'd2 : 4'd4, 1'b1, rs, rd, {9'd0, h[8:6]});
        else if (h[15:7] == 9'b010001110)
                r.instr = {4'b1110, 24'h12fff1, h[6:3]};                  // BX
        else if (h[15:12] == 4'b1101)
                r.instr = {h[11:8], 4'b1010, {16{h[7]}}, h[7:0]};
        else if (h[15:11] == 5'b11100)
                r.instr = {4'b1110, 4'b1010, {13{h[10]}}, h[10:0]};
        else if (h[15:13] == 3'b000)
                r.instr = arm_dp(1'b0, 4'd13, 1'b1, 4'd0, rd, {h[10:6], h[12:11], 1'b0, rs});
        else if (h[15:13] == 3'b001)
                r.instr = arm_dp(1'b1, imm_op, 1'b1, r8, r8, {4'd0, h[7:0]});
        else if (h[15:10] == 6'b010000)
                r.instr = alu_low(h[9:6], rd, rs);
        else if (h[15:10] == 6'b010001 && h[9:8] != 2'd3)
                r.instr = arm_dp(1'b0, hi_op, h[8], {h[7], h[2:0]}, {h[7], h[2:0]},
                                 {8'd0, h[6], h[5:3]});
        else
                r.und = 1'b1;                   // Word stays zero
        return r;
endfunction

`endif

// File: verif/thumb_decode_tb.sv
////////////////////////////////////////
// Testbench for the multi-lane decoder.
// Checks run as concurrent assertions
// and the first failure ends the run.
////////////////////////////////////////

`include "thumb_decode_macros.svh"

module thumb_decode_tb;

import thumb_decode_pkg::*;

`include "thumb_expand_model.svh"

localparam int RESET_CYCLES = 4;
localparam int MASK_N       = 32;       // Random slot masks
localparam int RAND_N       = 200;      // Mixed strobes and gaps
localparam int STIM_CYCLES  = RESET_CYCLES + 40 + MASK_N + RAND_N + 8;  // 40 for directed lists
localparam int ISSUE_W      = $bits(issue_bundle_t);
localparam int TAG_DP       = 1;
localparam int TAG_CF       = 2;
localparam int TAG_UND      = 3;
localparam int TAG_MASK     = 4;
localparam int TAG_RAND     = 5;

logic          i_clk;
logic          i_rst_n;
logic          i_valid;
fetch_bundle_t i_fetch;
logic          o_valid;
issue_bundle_t o_issue;

logic [15:0]   dq[$];           // Directed halfwords of one list
issue_bundle_t sb_q[$];         // Expected groups in send order
int            tag_q[$];        // Test of each queued group
logic          stage1_vld;      // Expected strobe one stage in
logic          exp_valid;
issue_bundle_t exp_issue;
int            exp_tag;
logic [31:0]   lcg_state;

thumb_decode_top thumb_decode_top_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .i_fetch (i_fetch),
        .o_valid (o_valid),
        .o_issue (o_issue)
);

always #4 i_clk = ~i_clk;

function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
endfunction

function automatic string tag_name(input int tag);
        case (tag)
        TAG_DP:   return "data_processing";
        TAG_CF:   return "control_flow";
        TAG_UND:  return "undefined";
        TAG_MASK: return "slot_mask";
        TAG_RAND: return "random";
        default:  return "idle";
        endcase
endfunction

function automatic issue_bundle_t expect_bundle(input fetch_bundle_t f);
        issue_bundle_t b;
        for (int k = 0; k < `THUMB_LANES; k++)
                b[k] = expand_half(f.word[k*`HALF_W +: `HALF_W], f.mask[k]);
        return b;
endfunction

task automatic stop_fail();
        $display("tests failed");
        $fatal(1, "run stopped on first error");
endtask

task automatic report_mismatch(input string name, input logic [ISSUE_W-1:0] exp_v,
                               input logic [ISSUE_W-1:0] act_v);
        $display("MISMATCH %s expected %h actual %h", name, exp_v, act_v);
        stop_fail();
endtask

// One strobe with its expected group queued only when a slot is live
task automatic send(input fetch_bundle_t f, input int tag);
        @(posedge i_clk);
        i_valid <= 1'b1;
        i_fetch <= f;
        if (|f.mask)
        begin
                sb_q.push_back(expect_bundle(f));
                tag_q.push_back(tag);
        end
endtask

task automatic idle(input int n);
        repeat (n)
        begin
                @(posedge i_clk);
                i_valid <= 1'b0;
        end
endtask

// Packs dq into back-to-back words with short tail slots masked off
task automatic run_list(input int tag);
        fetch_bundle_t f;
        int            idx;
        idx = 0;
        while (idx < dq.size())
        begin
                f = '0;
                for (int k = 0; k < `THUMB_LANES; k++)
                begin
                        if (idx < dq.size())
                        begin
                                f.word[k*`HALF_W +: `HALF_W] = dq[idx];
                                f.mask[k]                    = 1'b1;
                        end
                        idx++;
                end
                send(f, tag);
        end
        idle(2);
endtask

task automatic random_fetch(input logic rand_mask, output fetch_bundle_t f);
        f = '0;
        for (int k = 0; k < `THUMB_LANES; k++)
        begin
                lcg_state = lcg_step(lcg_state);
                f.word[k*`HALF_W +: `HALF_W] = lcg_state[31:16];
        end
        lcg_state = lcg_step(lcg_state);
        f.mask    = rand_mask ? lcg_state[`THUMB_LANES+7:8] : '1;
endtask

////////////////////////////////////////
// Two-stage expected timing
////////////////////////////////////////

always @(posedge i_clk or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                stage1_vld <= 1'b0;
                exp_valid  <= 1'b0;
                exp_issue  <= '0;
                exp_tag    <= 0;
        end
        else
        begin
                stage1_vld <= i_valid && (|i_fetch.mask);
                exp_valid  <= stage1_vld;
                if (stage1_vld)
                begin
                        exp_issue <= sb_q.pop_front();  // Held like the issue register
                        exp_tag   <= tag_q.pop_front();
                end
        end
end

a_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_valid == exp_valid)
        else report_mismatch("latency", $sampled(exp_valid), $sampled(o_valid));

a_issue: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid |-> o_issue == exp_issue)
        else report_mismatch(tag_name($sampled(exp_tag)), $sampled(exp_issue), $sampled(o_issue));

for (genvar k = 0; k < `THUMB_LANES; k++)
begin : g_lane_chk
        // Undefined lane is valid with a zero word
        a_und_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                o_issue[k].und |-> o_issue[k].valid && o_issue[k].instr == '0)
                else report_mismatch("undefined_word", {32'd0, 2'b11}, $sampled(o_issue[k]));
        a_slot_off: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                !o_issue[k].valid |-> o_issue[k] == '0)
                else report_mismatch("slot_off", '0, $sampled(o_issue[k]));
end

initial
begin
        #((STIM_CYCLES + 20) * 8);
        $display("Timeout after %0d cycles, queue still holds %0d groups",
                 STIM_CYCLES + 20, sb_q.size());
        stop_fail();
end

////////////////////////////////////////
// Stimulus
////////////////////////////////////////

initial
begin
        fetch_bundle_t f;
        logic [15:0]   alu_half;
        i_clk     = 1'b0;
        i_rst_n   = 1'b0;
        i_valid   = 1'b0;
        i_fetch   = '0;
        lcg_state = 32'd67558;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst_n <= 1'b1;
        idle(2);

        // Shift, add/sub, imm8, then all ALU-low ops and hi-register ops
        dq = '{16'h0088, 16'h0e53, 16'h17ff, 16'h0000, 16'h1888, 16'h1a51, 16'h1c4a,
               16'h1fff, 16'h20ff, 16'h2980, 16'h3201, 16'h3b7f};
        for (int op = 0; op < 16; op++)
        begin
                alu_half = {6'b010000, 4'(op), 3'(op + 3), 3'(op * 5)};
                dq.push_back(alu_half);
        end
        dq.push_back(16'h4488);
        dq.push_back(16'h45f7);
        dq.push_back(16'h4663);
        run_list(TAG_DP);

        // Branches both ways, SWI, BX low and high
        dq = '{16'hd005, 16'hd1f0, 16'hdc7f, 16'hd880, 16'he3ff, 16'he400, 16'he001,
               16'hdf00, 16'hdfab, 16'h4708, 16'h4778, 16'h4740};
        run_list(TAG_CF);

        // Loads, push/pop, BL pair, BLX, bkpt, stack, then two kept ones
        dq = '{16'h6808, 16'h4801, 16'hb5f0, 16'hbc0f, 16'hf000, 16'hf801, 16'h47c8,
               16'hbe01, 16'ha801, 16'hc00f, 16'h2001, 16'h4011};
        run_list(TAG_UND);

        for (int n = 0; n < MASK_N; n++)
        begin
                random_fetch(1'b1, f);
                send(f, TAG_MASK);
        end
        idle(2);

        for (int n = 0; n < RAND_N; n++)
        begin
                lcg_state = lcg_step(lcg_state);
                if (lcg_state[18:17] == 2'b00)
                        idle(1);
                else
                begin
                        random_fetch(lcg_state[19] & lcg_state[20], f);
                        send(f, TAG_RAND);
                end
        end
        idle(1);

        while (sb_q.size() != 0)
                @(posedge i_clk);
        idle(3);
        $display("all tests passed");
        $finish;
end

endmodule

// File: compile.f
+incdir+src
+incdir+verif
src/thumb_decode_pkg.sv
src/thumb_fetch_split.sv
src/thumb_lane_expand.sv
src/thumb_issue_collect.sv
src/thumb_decode_top.sv
verif/thumb_decode_tb.sv
